/* mem_subsys_top.f */
mmio_pkg.sv
mem_req_if.sv
mmio_router.sv
dcache_direct.sv
clint_timer.sv
bus_arbiter.sv
mem_subsys_top.sv
tb_axi_slave.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
    -f mem_subsys_top.f -o tb_mem_subsys > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_mem_subsys > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

/* tb_mem_subsys.sv */
`timescale 1ns/10ps

module tb_mem_subsys;

    localparam logic [63:0] ram_base   = 64'h0000_0000_8000_0000;
    localparam logic [63:0] chip_base  = 64'h0000_0000_4000_0000;
    localparam logic [63:0] uart_addr  = 64'h0000_0000_1000_0010;
    localparam logic [63:0] cmp_addr   = 64'h0000_0000_0200_4000;
    localparam logic [63:0] mtime_addr = 64'h0000_0000_0200_bff8;
    // about 250 accesses at up to 40 cycles each plus the irq wait, doubled.
    localparam int timeout_cycles = 20000;

    logic        clk;
    logic        rst_n;
    logic [63:0] core_addr;
    logic [63:0] core_wdata;
    logic [7:0]  core_mask;
    logic        core_we;
    logic        core_re;
    logic        fence;
    logic [63:0] core_rdata;
    logic        core_finish;
    logic        timer_irq;
    logic        awvalid;
    logic        awready;
    logic [63:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic        arvalid;
    logic        arready;
    logic [63:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [63:0] rdata;
    int          ar_count;
    int          aw_count;

    logic [63:0] shadow [logic [60:0]];
    logic [15:0] lfsr = 16'd97;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          finish_count = 0;
    int          expected_finishes = 0;
    int          cycles = 0;

    mem_subsys_top #(.line_count(16)) dut_i (.*);

    tb_axi_slave #(.seed(16'd97)) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (core_finish === 1'b1) begin
            finish_count++;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // expected memory contents, unwritten words follow the slave fill pattern.
    function automatic logic [63:0] ref_read(input logic [63:0] addr);
        if (shadow.exists(addr[63:3])) begin
            return shadow[addr[63:3]];
        end
        return {addr[63:3], 3'b000} ^ 64'h9e37_79b9_7f4a_7c15;
    endfunction

    task automatic ref_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] mask);
        logic [63:0] word;
        word = ref_read(addr);
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        shadow[addr[63:3]] = word;
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // request is held until core_finish, then dropped.
    task automatic bus_access(input logic [63:0] addr, input logic we, input logic [63:0] data,
                              input logic [7:0] mask, output logic [63:0] rd);
        core_addr  = addr;
        core_wdata = data;
        core_mask  = mask;
        core_we    = we;
        core_re    = !we;
        @(negedge clk);
        while (!core_finish) @(negedge clk);
        rd = core_rdata;
        @(posedge clk);
        #1;
        core_we = 1'b0;
        core_re = 1'b0;
        expected_finishes++;
    endtask

    task automatic write_word(input logic [63:0] addr, input logic [63:0] data,
                              input logic [7:0] mask);
        logic [63:0] ignored;
        bus_access(addr, 1'b1, data, mask, ignored);
        ref_write(addr, data, mask);
    endtask

    task automatic read_word(input logic [63:0] addr, output logic [63:0] rd);
        bus_access(addr, 1'b0, '0, 8'hff, rd);
        check("core_rdata", rd, ref_read(addr));
    endtask

    task automatic issue_fence();
        core_addr = ram_base;  // the cache answers a fence.
        fence     = 1'b1;
        @(negedge clk);
        while (!core_finish) @(negedge clk);
        @(posedge clk);
        #1;
        fence = 1'b0;
        expected_finishes++;
    endtask

    task automatic end_test(input string name, input int err0);
        check("core_finish count", 64'(finish_count), 64'(expected_finishes));
        tests_run++;
        if (errors == err0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
        end
    endtask

    initial begin : timeout
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        logic [63:0] rd;
        logic [63:0] t0;
        logic [63:0] addr;
        logic [63:0] data;
        logic [7:0]  mask;
        int          ar0;
        int          aw0;
        int          err0;
        int          waited;
        rst_n      = 1'b0;
        core_addr  = ram_base;
        core_wdata = '0;
        core_mask  = '0;
        core_we    = 1'b0;
        core_re    = 1'b0;
        fence      = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        err0 = errors;
        aw0  = aw_count;
        addr = ram_base + 64'h100;
        write_word(addr, 64'h1111_2222_3333_4444, 8'h0f);
        write_word(addr, 64'h5555_6666_7777_8888, 8'hf0);
        write_word(addr, 64'h9999_aaaa_bbbb_cccc, 8'h3c);
        read_word(addr, rd);
        write_word(addr, 64'hdddd_eeee_ffff_0000, 8'h81);  // hit, merged into the line.
        read_word(addr, rd);
        check("aw_count", 64'(aw_count - aw0), 64'd4);
        end_test("cached write and read", err0);

        err0 = errors;
        ar0  = ar_count;
        addr = ram_base + 64'h208;
        read_word(addr, rd);
        read_word(addr, rd);
        check("ar_count", 64'(ar_count - ar0), 64'd1);
        data = ~ref_read(addr);
        mem_i.poke(addr, data);
        read_word(addr, rd);  // stale line.
        shadow[addr[63:3]] = data;
        issue_fence();
        read_word(addr, rd);
        check("ar_count", 64'(ar_count - ar0), 64'd2);
        end_test("hit and fence", err0);

        err0 = errors;
        ar0  = ar_count;
        mem_i.poke(uart_addr, 64'h0000_00a5_0000_005a);
        shadow[uart_addr[63:3]] = 64'h0000_00a5_0000_005a;
        read_word(uart_addr, rd);
        read_word(uart_addr, rd);
        check("ar_count", 64'(ar_count - ar0), 64'd2);
        end_test("uncached path", err0);

        err0 = errors;
        ar0  = ar_count;
        aw0  = aw_count;
        bus_access(cmp_addr, 1'b0, '0, 8'hff, rd);
        check("mtimecmp", rd, '1);
        bus_access(cmp_addr, 1'b1, 64'h0000_1234_5678_9abc, 8'hff, rd);
        bus_access(cmp_addr, 1'b0, '0, 8'hff, rd);
        check("mtimecmp", rd, 64'h0000_1234_5678_9abc);
        bus_access(mtime_addr, 1'b0, '0, 8'hff, t0);
        bus_access(mtime_addr, 1'b0, '0, 8'hff, rd);
        check("mtime increases", 64'(rd > t0), 64'd1);
        bus_access(cmp_addr, 1'b1, rd + 64'd300, 8'hff, t0);
        @(negedge clk);
        check("timer_irq", 64'(timer_irq), 64'd0);
        waited = 0;
        while (!timer_irq && (waited < 340)) begin
            @(negedge clk);
            waited++;
        end
        check("timer_irq", 64'(timer_irq), 64'd1);
        check("ar_count", 64'(ar_count - ar0), 64'd0);
        check("aw_count", 64'(aw_count - aw0), 64'd0);
        @(posedge clk);
        #1;
        end_test("clint", err0);

        err0 = errors;
        for (int n = 0; n < 200; n++) begin
            if (rand_bits(2) == 0) begin
                addr = chip_base + 64'({rand_bits(4), 3'b000});
            end else begin
                addr = ram_base + 64'({rand_bits(6), 3'b000});
            end
            if (rand_bits(1) != 0) begin
                data[63:32] = rand_bits(32);
                data[31:0]  = rand_bits(32);
                mask        = 8'(rand_bits(8));
                write_word(addr, data, mask);
            end else begin
                read_word(addr, rd);
            end
        end
        end_test("mixed random traffic", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* tb_axi_slave.sv */
`timescale 1ns/10ps

module tb_axi_slave #(
    parameter logic [15:0] seed = 16'd97
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        awvalid,
    output logic        awready,
    input  logic [63:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [63:0] wdata,
    input  logic [7:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    input  logic        arvalid,
    output logic        arready,
    input  logic [63:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [63:0] rdata,
    output int          ar_count,
    output int          aw_count
);

    logic [63:0] mem [logic [60:0]];  // one entry per 64-bit word.
    logic [15:0] lfsr = seed;

    // two lfsr bits give 0 to 3 wait cycles.
    function automatic logic [1:0] pick_delay();
        logic [1:0] d;
        d = '0;
        for (int i = 0; i < 2; i++) begin
            d = {d[0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return d;
    endfunction

    function automatic logic [63:0] word_at(input logic [63:0] addr);
        if (mem.exists(addr[63:3])) begin
            return mem[addr[63:3]];
        end
        return {addr[63:3], 3'b000} ^ 64'h9e37_79b9_7f4a_7c15;  // never written.
    endfunction

    task automatic poke(input logic [63:0] addr, input logic [63:0] data);
        mem[addr[63:3]] = data;
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    initial begin : read_side
        logic [63:0] addr;
        logic [1:0]  d;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        ar_count = 0;
        forever begin
            @(negedge clk);
            if (rst_n && arvalid) begin
                addr = araddr;
                d = pick_delay();
                repeat (d + 1) next_edge();
                arready = 1'b1;
                next_edge();
                arready = 1'b0;
                ar_count++;
                repeat (pick_delay()) next_edge();
                rdata  = word_at(addr);
                rvalid = 1'b1;
                @(negedge clk);
                while (!rready) @(negedge clk);
                next_edge();
                rvalid = 1'b0;
            end
        end
    end

    initial begin : write_side
        logic [63:0] addr;
        logic [63:0] data;
        logic [63:0] word;
        logic [7:0]  strb;
        logic [1:0]  d_aw;
        logic [1:0]  d_w;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        aw_count = 0;
        forever begin
            @(negedge clk);
            if (rst_n && (awvalid || wvalid)) begin
                addr = awaddr;
                data = wdata;
                strb = wstrb;
                d_aw = pick_delay();
                d_w  = pick_delay();
                // aw and w are accepted independently.
                for (int c = 0; (c <= int'(d_aw)) || (c <= int'(d_w)); c++) begin
                    next_edge();
                    awready = (c == int'(d_aw));
                    wready  = (c == int'(d_w));
                end
                next_edge();
                awready = 1'b0;
                wready  = 1'b0;
                word = word_at(addr);
                for (int i = 0; i < 8; i++) begin
                    if (strb[i]) begin
                        word[8*i +: 8] = data[8*i +: 8];
                    end
                end
                mem[addr[63:3]] = word;
                aw_count++;
                repeat (pick_delay()) next_edge();
                bvalid = 1'b1;
                @(negedge clk);
                while (!bready) @(negedge clk);
                next_edge();
                bvalid = 1'b0;
            end
        end
    end

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top #(
    parameter int line_count = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [mmio_pkg::addr_w-1:0] core_addr,
    input  logic [mmio_pkg::data_w-1:0] core_wdata,
    input  logic [mmio_pkg::mask_w-1:0] core_mask,
    input  logic                        core_we,
    input  logic                        core_re,
    input  logic                        fence,
    output logic [mmio_pkg::data_w-1:0] core_rdata,
    output logic                        core_finish,
    output logic                        timer_irq,
    output logic                        awvalid,
    input  logic                        awready,
    output logic [mmio_pkg::addr_w-1:0] awaddr,
    output logic                        wvalid,
    input  logic                        wready,
    output logic [mmio_pkg::data_w-1:0] wdata,
    output logic [mmio_pkg::mask_w-1:0] wstrb,
    input  logic                        bvalid,
    output logic                        bready,
    output logic                        arvalid,
    input  logic                        arready,
    output logic [mmio_pkg::addr_w-1:0] araddr,
    input  logic                        rvalid,
    output logic                        rready,
    input  logic [mmio_pkg::data_w-1:0] rdata
);

    mem_req_if core_bus   (.clk(clk));
    mem_req_if clint_bus  (.clk(clk));
    mem_req_if unc_bus    (.clk(clk));
    mem_req_if cache_bus  (.clk(clk));
    mem_req_if refill_bus (.clk(clk));

    assign core_bus.addr  = core_addr;
    assign core_bus.wdata = core_wdata;
    assign core_bus.mask  = core_mask;
    assign core_bus.we    = core_we;
    assign core_bus.re    = core_re;
    assign core_rdata     = core_bus.rdata;
    assign core_finish    = core_bus.finish;

    mmio_router router_i (
        .core_bus  (core_bus.responder),
        .clint_bus (clint_bus.requester),
        .unc_bus   (unc_bus.requester),
        .cache_bus (cache_bus.requester)
    );

    dcache_direct #(.line_count(line_count)) dcache_i (
        .clk   (clk),
        .rst_n (rst_n),
        .fence (fence),
        .cpu   (cache_bus.responder),
        .mem   (refill_bus.requester)
    );

    clint_timer clint_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (clint_bus.responder),
        .timer_irq (timer_irq)
    );

    bus_arbiter arbiter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .port0   (refill_bus.responder),
        .port1   (unc_bus.responder),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata)
    );

endmodule

/* bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    mem_req_if.responder                port0,
    mem_req_if.responder                port1,
    output logic                        awvalid,
    input  logic                        awready,
    output logic [mmio_pkg::addr_w-1:0] awaddr,
    output logic                        wvalid,
    input  logic                        wready,
    output logic [mmio_pkg::data_w-1:0] wdata,
    output logic [mmio_pkg::mask_w-1:0] wstrb,
    input  logic                        bvalid,
    output logic                        bready,
    output logic                        arvalid,
    input  logic                        arready,
    output logic [mmio_pkg::addr_w-1:0] araddr,
    input  logic                        rvalid,
    output logic                        rready,
    input  logic [mmio_pkg::data_w-1:0] rdata
);
    import mmio_pkg::*;

    bus_state_e        state;
    logic [1:0]        grant;
    logic              prio;  // port that wins a tie.
    logic              req0;
    logic              req1;
    logic              pick;
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] wdata_q;
    logic [mask_w-1:0] mask_q;
    logic [data_w-1:0] rdata_q;

    assign req0 = port0.we || port0.re;
    assign req1 = port1.we || port1.re;
    assign pick = (req0 && req1) ? prio : req1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= bus_idle;
            grant   <= '0;
            prio    <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                bus_idle: begin
                    if (req0 || req1) begin
                        grant <= pick ? 2'b10 : 2'b01;
                        prio  <= ~pick;
                        if (pick ? port1.we : port0.we) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= bus_aw_w;
                        end else begin
                            arvalid <= 1'b1;
                            state   <= bus_ar;
                        end
                    end
                end
                bus_ar: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= bus_r;
                    end
                end
                bus_r: begin
                    if (rvalid) begin
                        state <= bus_done;
                    end
                end
                bus_aw_w: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if ((!awvalid || awready) && (!wvalid || wready)) begin
                        state <= bus_b;
                    end
                end
                bus_b: begin
                    if (bvalid) begin
                        state <= bus_done;  // bresp ignored.
                    end
                end
                bus_done: begin
                    grant <= '0;
                    state <= bus_idle;
                end
                default: state <= bus_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bus_idle) begin
            addr_q  <= pick ? port1.addr : port0.addr;
            wdata_q <= pick ? port1.wdata : port0.wdata;
            mask_q  <= pick ? port1.mask : port0.mask;
        end
        if ((state == bus_r) && rvalid) begin
            rdata_q <= rdata;
        end
    end

    assign awaddr = addr_q;
    assign araddr = addr_q;
    assign wdata  = wdata_q;
    assign wstrb  = mask_q;
    assign rready = (state == bus_r);
    assign bready = (state == bus_b);

    assign port0.rdata  = rdata_q;
    assign port0.finish = (state == bus_done) && grant[0];
    assign port1.rdata  = rdata_q;
    assign port1.finish = (state == bus_done) && grant[1];

    assert property (@(posedge clk) disable iff (!rst_n) (state != bus_idle) |-> $onehot(grant));

    assert property (@(posedge clk) disable iff (!rst_n) arvalid && !arready |=> arvalid);

endmodule

/* clint_timer.sv */
`timescale 1ns/10ps

module clint_timer (
    input  logic         clk,
    input  logic         rst_n,
    mem_req_if.responder req,
    output logic         timer_irq
);
    import mmio_pkg::*;

    logic [data_w-1:0] mtime;
    logic [data_w-1:0] mtimecmp;
    logic [data_w-1:0] rdata_q;
    logic              finish_q;
    logic [15:0]       offset;
    logic              access;
    logic              wr_mtime;
    logic              wr_mtimecmp;

    assign offset      = req.addr[15:0];
    assign access      = (req.we || req.re) && !finish_q;  // one access per held request.
    assign wr_mtime    = access && req.we && (offset == mtime_off);
    assign wr_mtimecmp = access && req.we && (offset == mtimecmp_off);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime     <= '0;
            mtimecmp  <= '1;
            finish_q  <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            finish_q  <= access;
            timer_irq <= (mtime >= mtimecmp);
            if (wr_mtime) begin
                mtime <= merge_bytes(mtime, req.wdata, req.mask);
            end else begin
                mtime <= mtime + 1'b1;
            end
            if (wr_mtimecmp) begin
                mtimecmp <= merge_bytes(mtimecmp, req.wdata, req.mask);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (offset)
                mtime_off:    rdata_q <= mtime;
                mtimecmp_off: rdata_q <= mtimecmp;
                default:      rdata_q <= '0;  // unmapped.
            endcase
        end
    end

    assign req.rdata  = rdata_q;
    assign req.finish = finish_q;

endmodule

/* dcache_direct.sv */
`timescale 1ns/10ps

module dcache_direct #(
    parameter int line_count = 16
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         fence,
    mem_req_if.responder cpu,
    mem_req_if.requester mem
);
    import mmio_pkg::*;

    localparam int idx_w = $clog2(line_count);
    localparam int tag_w = addr_w - 3 - idx_w;

    dc_state_e             state;
    logic [tag_w-1:0]      tag_mem [line_count];
    logic [data_w-1:0]     data_mem [line_count];
    logic [line_count-1:0] valid;
    logic [data_w-1:0]     rdata_q;
    logic [idx_w-1:0]      idx;
    logic [tag_w-1:0]      tag;
    logic                  hit;
    logic                  refill_go;
    logic                  write_go;

    assign idx = cpu.addr[3 +: idx_w];
    assign tag = cpu.addr[addr_w-1 -: tag_w];
    assign hit = valid[idx] && (tag_mem[idx] == tag);

    assign refill_go = (state == dc_refill);
    assign write_go  = (state == dc_write);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= dc_idle;
            valid <= '0;
        end else begin
            case (state)
                dc_idle: begin
                    if (fence || cpu.we || cpu.re) begin
                        state <= dc_lookup;
                    end
                end
                dc_lookup: begin
                    if (fence) begin
                        valid <= '0;
                        state <= dc_done;
                    end else if (cpu.we) begin
                        state <= dc_write;  // write-through, hit or miss.
                    end else if (hit) begin
                        state <= dc_done;
                    end else begin
                        state <= dc_refill;
                    end
                end
                dc_refill: begin
                    if (mem.finish) begin
                        valid[idx] <= 1'b1;
                        state      <= dc_done;
                    end
                end
                dc_write: begin
                    if (mem.finish) begin
                        state <= dc_done;
                    end
                end
                dc_done: state <= dc_idle;
                default: state <= dc_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == dc_lookup) && hit) begin
            rdata_q <= data_mem[idx];
        end
        if (refill_go && mem.finish) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= mem.rdata;
            rdata_q       <= mem.rdata;
        end
        // no allocate on a write miss.
        if (write_go && mem.finish && hit) begin
            data_mem[idx] <= merge_bytes(data_mem[idx], cpu.wdata, cpu.mask);
        end
    end

    assign mem.re    = refill_go;
    assign mem.we    = write_go;
    assign mem.addr  = refill_go ? {cpu.addr[addr_w-1:3], 3'b000} : cpu.addr;
    assign mem.wdata = cpu.wdata;
    assign mem.mask  = refill_go ? {mask_w{1'b1}} : cpu.mask;

    assign cpu.rdata  = rdata_q;
    assign cpu.finish = (state == dc_done);

    assert property (@(posedge clk) disable iff (!rst_n) cpu.finish |=> !cpu.finish);

    assert property (@(posedge clk) disable iff (!rst_n) !(mem.we && mem.re));

endmodule

/* mmio_router.sv */
`timescale 1ns/10ps

module mmio_router (
    mem_req_if.responder core_bus,
    mem_req_if.requester clint_bus,
    mem_req_if.requester unc_bus,
    mem_req_if.requester cache_bus
);
    import mmio_pkg::*;

    route_e route;

    function automatic logic in_window(
        input logic [addr_w-1:0] a,
        input logic [addr_w-1:0] lo,
        input logic [addr_w-1:0] hi
    );
        return (a >= lo) && (a <= hi);
    endfunction

    always_comb begin
        if (in_window(core_bus.addr, clint_start, clint_end)) begin
            route = route_clint;
        end else if (in_window(core_bus.addr, uart_start, uart_end) ||
                     in_window(core_bus.addr, spi_start, spi_end) ||
                     in_window(core_bus.addr, chiplink_start, chiplink_end)) begin
            route = route_uncached;
        end else begin
            route = route_cached;
        end
    end

    assign clint_bus.addr  = core_bus.addr;
    assign clint_bus.wdata = core_bus.wdata;
    assign clint_bus.mask  = core_bus.mask;
    assign clint_bus.we    = core_bus.we && (route == route_clint);
    assign clint_bus.re    = core_bus.re && (route == route_clint);

    assign unc_bus.addr    = core_bus.addr;
    assign unc_bus.wdata   = core_bus.wdata;
    assign unc_bus.mask    = core_bus.mask;
    assign unc_bus.we      = core_bus.we && (route == route_uncached);
    assign unc_bus.re      = core_bus.re && (route == route_uncached);

    assign cache_bus.addr  = core_bus.addr;
    assign cache_bus.wdata = core_bus.wdata;
    assign cache_bus.mask  = core_bus.mask;
    assign cache_bus.we    = core_bus.we && (route == route_cached);
    assign cache_bus.re    = core_bus.re && (route == route_cached);

    always_comb begin
        case (route)
            route_clint: begin
                core_bus.rdata  = clint_bus.rdata;
                core_bus.finish = clint_bus.finish;
            end
            route_uncached: begin
                core_bus.rdata  = unc_bus.rdata;
                core_bus.finish = unc_bus.finish;
            end
            default: begin
                core_bus.rdata  = cache_bus.rdata;
                core_bus.finish = cache_bus.finish;
            end
        endcase
    end

    // a fence completes on the cached route without we or re.
    assert property (@(posedge core_bus.clk)
        core_bus.finish && (route != route_cached) |-> (core_bus.we || core_bus.re));

endmodule

/* mem_req_if.sv */
`timescale 1ns/10ps

interface mem_req_if (input logic clk);
    import mmio_pkg::*;

    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [mask_w-1:0] mask;
    logic              we;
    logic              re;
    logic [data_w-1:0] rdata;   // valid while finish is high.
    logic              finish;  // one-cycle pulse.

    modport requester (
        input  clk,
        output addr, wdata, mask, we, re,
        input  rdata, finish
    );

    modport responder (
        input  clk,
        input  addr, wdata, mask, we, re,
        output rdata, finish
    );

endinterface

/* mmio_pkg.sv */
package mmio_pkg;

    localparam int addr_w = 64;
    localparam int data_w = 64;
    localparam int mask_w = 8;

    localparam logic [addr_w-1:0] clint_start    = 64'h0000_0000_0200_0000;
    localparam logic [addr_w-1:0] clint_end      = 64'h0000_0000_0200_ffff;
    localparam logic [addr_w-1:0] uart_start     = 64'h0000_0000_1000_0000;
    localparam logic [addr_w-1:0] uart_end       = 64'h0000_0000_1000_0fff;
    localparam logic [addr_w-1:0] spi_start      = 64'h0000_0000_3000_0000;
    localparam logic [addr_w-1:0] spi_end        = 64'h0000_0000_3fff_ffff;
    localparam logic [addr_w-1:0] chiplink_start = 64'h0000_0000_4000_0000;
    localparam logic [addr_w-1:0] chiplink_end   = 64'h0000_0000_7fff_ffff;

    localparam logic [15:0] mtimecmp_off = 16'h4000;
    localparam logic [15:0] mtime_off    = 16'hbff8;

    typedef enum logic [1:0] {route_clint, route_uncached, route_cached} route_e;

    typedef enum logic [2:0] {dc_idle, dc_lookup, dc_refill, dc_write, dc_done} dc_state_e;

    typedef enum logic [2:0] {bus_idle, bus_ar, bus_r, bus_aw_w, bus_b, bus_done} bus_state_e;

    // byte lanes set in mask take the new word.
    function automatic logic [data_w-1:0] merge_bytes(
        input logic [data_w-1:0] old_word,
        input logic [data_w-1:0] new_word,
        input logic [mask_w-1:0] mask
    );
        logic [data_w-1:0] result;
        result = old_word;
        for (int i = 0; i < mask_w; i++) begin
            if (mask[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

endpackage
